// ==== filelist.f ====
source/u1plus_pkg.sv
source/wb_decoder.sv
source/misc_regs.sv
source/settings_bus_16le.sv
source/vita_time_64.sv
source/readback_mux_16le.sv
source/u1plus_ctrl_core.sv
bench/u1plus_ctrl_sva.sv
bench/tb_u1plus_ctrl_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the control core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_u1plus_ctrl_core \
   -o sim_tb

./obj_dir/sim_tb

// ==== bench/tb_u1plus_ctrl_core.sv ====
`timescale 1ns/1ps

module tb_u1plus_ctrl_core import u1plus_pkg::*;
();

   localparam int unsigned TPS             = 50;
   localparam int unsigned MAX_XFERS       = 400;
   localparam int unsigned XFER_CYCLES     = 50;   // generous per transfer
   localparam int unsigned WATCHDOG_CYCLES = MAX_XFERS * XFER_CYCLES;

   logic        wb_clk, wb_rst;
   wb_adr_t     wb_adr;
   wb_dat_t     wb_dat_w, wb_dat_r;
   logic        wb_we, wb_cyc, wb_stb, wb_ack;
   logic        st_status, st_ld, st_refmon;
   logic        sync_b, ref_sel, pps;
   logic [31:0] lcg_state = 32'hd2894cf3;
   int unsigned cycle_cnt = 0;

   u1plus_ctrl_core #(.ticks_per_sec(TPS)) dut0
      (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
       .wb_dat_o(wb_dat_r), .wb_we_i(wb_we), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
       .wb_ack_o(wb_ack), .cgen_st_status_i(st_status), .cgen_st_ld_i(st_ld),
       .cgen_st_refmon_i(st_refmon), .cgen_sync_b_o(sync_b), .cgen_ref_sel_o(ref_sel),
       .pps_i(pps));

   initial
   begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cycle_cnt <= cycle_cnt + 1;

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic wb_adr_t misc_adr(input logic [6:0] off);
      return {SLAVE_MISC_ADDR, off};
   endfunction

   function automatic wb_adr_t rb_adr(input logic [3:0] word, input logic hi);
      return {SLAVE_READBACK_ADDR, 1'b0, word, hi, 1'b0};
   endfunction

   function automatic wb_adr_t set_adr(input set_addr_t num, input logic hi);
      return {1'b1, num, hi, 1'b0};
   endfunction

   // time as a single tick count
   function automatic logic [63:0] to_ticks(input logic [31:0] secs, input logic [31:0] ticks);
      return 64'(secs) * 64'(TPS) + 64'(ticks);
   endfunction

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got == exp)
      else
      begin
         $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_range(input logic [63:0] got, input logic [63:0] lo,
                              input logic [63:0] hi, input string what);
      assert (got >= lo && got <= hi)
      else
      begin
         $display("Fail %0t: %s, got %0d expected %0d..%0d", $time, what, got, lo, hi);
         abort_run();
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge wb_clk);
      #2;
   endtask

   // hold the request until ack is seen, then release after that edge
   task automatic wb_xfer(input wb_adr_t adr, input wb_dat_t dat, input logic we,
                          output wb_dat_t rd);
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_we    = we;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      do
         @(negedge wb_clk);
      while (!wb_ack);
      rd = wb_dat_r;
      @(posedge wb_clk);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      wb_xfer(adr, dat, 1'b1, unused);
   endtask

   task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
      wb_xfer(adr, 16'd0, 1'b0, dat);
   endtask

   task automatic probe_no_ack(input wb_adr_t adr);
      wb_adr = adr;
      wb_we  = 1'b0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      repeat (8)
      begin
         @(negedge wb_clk);
         check_eq(32'(wb_ack), 32'd0, "ack from unmapped address");
      end
      @(posedge wb_clk);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic write_setting(input set_addr_t num, input logic [31:0] val);
      wb_write(set_adr(num, 1'b0), val[15:0]);  // low half first
      wb_write(set_adr(num, 1'b1), val[31:16]);
   endtask

   task automatic read_word(input logic [3:0] word, output logic [31:0] val);
      wb_dat_t lo, hi;
      wb_read(rb_adr(word, 1'b0), lo);
      wb_read(rb_adr(word, 1'b1), hi);
      val = {hi, lo};
   endtask

   // seconds first, a carry in between can only make it smaller
   task automatic read_time_floor(output logic [63:0] t);
      logic [31:0] secs, ticks;
      read_word(4'd0, secs);
      read_word(4'd1, ticks);
      t = to_ticks(secs, ticks);
   endtask

   // ticks first, a carry in between can only make it larger
   task automatic read_time_ceiling(output logic [63:0] t);
      logic [31:0] secs, ticks;
      read_word(4'd1, ticks);
      read_word(4'd0, secs);
      t = to_ticks(secs, ticks);
   endtask

   task automatic pps_pulse();
      pps = 1'b1;
      idle(5);
      pps = 1'b0;
      idle(2);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial
   begin
      logic [31:0] rnd, val, s_load, s_pps, s_now;
      logic [63:0] t_val, t_before, t_after, t_load;
      wb_dat_t     rd, test16;
      logic [1:0]  ctrl;
      int unsigned c0;

      wb_rst    = 1'b1;
      wb_adr    = '0;
      wb_dat_w  = '0;
      wb_we     = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      st_status = 1'b0;
      st_ld     = 1'b0;
      st_refmon = 1'b0;
      pps       = 1'b0;
      test16    = '0;
      repeat (4) @(posedge wb_clk);
      #2;
      wb_rst = 1'b0;
      idle(2);

      check_eq(32'({sync_b, ref_sel}), 32'd3, "clock generator outputs after reset");
      for (int i = 0; i < 4; i++)
      begin
         rnd    = next_rand();
         ctrl   = rnd[1:0];
         test16 = rnd[31:16];
         {st_status, st_ld, st_refmon} = rnd[4:2];
         wb_write(misc_adr(REG_CGEN_CTRL), {14'd0, ctrl});
         check_eq(32'({sync_b, ref_sel}), 32'(ctrl), "clock generator outputs");
         wb_write(misc_adr(REG_TEST), test16);
         wb_read(misc_adr(REG_TEST), rd);
         check_eq(32'(rd), 32'(test16), "misc test register");
         wb_read(misc_adr(REG_CGEN_ST), rd);
         check_eq(32'(rd), {29'd0, rnd[4:2]}, "clock generator status");
      end
      wb_read(misc_adr(7'd2), rd);
      check_eq(32'(rd), 32'h0000_beef, "unmapped misc offset");

      // 32-bit test setting and fixed words
      val = next_rand();
      write_setting(SR_REG_TEST32, val);
      read_word(4'd4, rnd);
      check_eq(rnd, val, "test setting readback");
      read_word(4'd6, rnd);
      check_eq(rnd, 32'h0009_0000, "compat number");
      read_word(4'd5, rnd);
      check_eq(rnd, 32'd0, "unused readback word");

      // immediate load
      rnd    = next_rand();
      s_load = {20'd0, rnd[11:0]} + 32'd100;
      write_setting(SR_TIME64, s_load);
      write_setting(SR_TIME64 + 8'd1, 32'd10);
      c0 = cycle_cnt;
      idle(3);
      read_time_floor(t_val);
      t_load = to_ticks(s_load, 32'd10);
      check_range(t_val, t_load, t_load + 64'(cycle_cnt - c0), "time after immediate load");
      idle(60);
      read_word(4'd0, s_now);
      check_range(64'(s_now), 64'(s_load) + 64'd1, 64'(s_load) + 64'd2,
                  "seconds after tick wrap");

      // pps latch
      read_time_floor(t_before);
      pps_pulse();
      read_time_ceiling(t_after);
      read_word(4'd2, s_now);
      read_word(4'd3, val);
      check_range(to_ticks(s_now, val), t_before, t_after, "pps time latch");

      // load at the next pps
      read_word(4'd0, s_now);
      s_pps = s_now + 32'd1000;
      write_setting(SR_TIME64 + 8'd2, 32'd1);
      write_setting(SR_TIME64, s_pps);
      write_setting(SR_TIME64 + 8'd1, 32'd0);
      idle(10);
      read_word(4'd0, val);
      check_range(64'(val), 64'(s_now), 64'(s_now) + 64'd1, "seconds while load is armed");
      pps_pulse();
      read_word(4'd0, val);
      check_range(64'(val), 64'(s_pps), 64'(s_pps) + 64'd1, "seconds after load at pps");

      // decode field 1 has no slave
      probe_no_ack({4'd1, 7'd0});
      wb_read(misc_adr(REG_TEST), rd);
      check_eq(32'(rd), 32'(test16), "misc read after unmapped probe");

      $display("Regression passed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk);
      $display("Watchdog expired after %0d cycles without the test finishing",
               WATCHDOG_CYCLES);
      abort_run();
   end

endmodule

// ==== bench/u1plus_ctrl_sva.sv ====
`timescale 1ns/1ps

module u1plus_ctrl_sva import u1plus_pkg::*;
#(
   parameter int unsigned ticks_per_sec = DEFAULT_TICKS_PER_SEC
)
(
   input logic    wb_clk,
   input logic    wb_rst,
   input wb_adr_t adr_i,
   input wb_dat_t rd_dat_i,
   input logic    we_i,
   input logic    cyc_i,
   input logic    stb_i,
   input logic    ack_i,
   input logic    sync_b_i,
   input logic    ref_sel_i
);

   // readback word 1 holds the ticks
   localparam wb_adr_t TICKS_LO_ADR = {SLAVE_READBACK_ADDR, 1'b0, 4'd1, 1'b0, 1'b0};
   localparam wb_adr_t TICKS_HI_ADR = {SLAVE_READBACK_ADDR, 1'b0, 4'd1, 1'b1, 1'b0};

   logic    ticks_lo_read, ticks_hi_read;
   wb_dat_t ticks_lo_q;   // low half of the last ticks read

   assign ticks_lo_read = ack_i && !we_i && (adr_i == TICKS_LO_ADR);
   assign ticks_hi_read = ack_i && !we_i && (adr_i == TICKS_HI_ADR);

   always_ff @(posedge wb_clk)
   begin
      if (ticks_lo_read)
         ticks_lo_q <= rd_dat_i;
   end

   ack_needs_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(ack_i) |-> (cyc_i && stb_i))
      else $error("ack rose without cyc and stb");

   cgen_after_reset: assert property (@(posedge wb_clk)
      $fell(wb_rst) |-> (sync_b_i && ref_sel_i))
      else $error("clock generator outputs not high after reset");

   // high half completes the ticks word
   ticks_range: assert property (@(posedge wb_clk) disable iff (wb_rst)
      ticks_hi_read |-> ({rd_dat_i, ticks_lo_q} < ticks_per_sec))
      else $error("ticks read back at or above ticks_per_sec");

endmodule

bind u1plus_ctrl_core u1plus_ctrl_sva #(.ticks_per_sec(ticks_per_sec)) sva0
   (.wb_clk(wb_clk), .wb_rst(wb_rst), .adr_i(wb_adr_i), .rd_dat_i(wb_dat_o),
    .we_i(wb_we_i), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .ack_i(wb_ack_o),
    .sync_b_i(cgen_sync_b_o), .ref_sel_i(cgen_ref_sel_o));

// ==== source/u1plus_ctrl_core.sv ====
`timescale 1ns/1ps

module u1plus_ctrl_core import u1plus_pkg::*;
#(
   parameter int unsigned ticks_per_sec = DEFAULT_TICKS_PER_SEC
)
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   output wb_dat_t wb_dat_o,
   input  logic    wb_we_i,
   input  logic    wb_cyc_i,
   input  logic    wb_stb_i,
   output logic    wb_ack_o,

   input  logic    cgen_st_status_i,
   input  logic    cgen_st_ld_i,
   input  logic    cgen_st_refmon_i,
   output logic    cgen_sync_b_o,
   output logic    cgen_ref_sel_o,

   input  logic    pps_i
);

   logic       misc_stb, rb_stb, sb_stb;
   logic       misc_ack, rb_ack, sb_ack;
   wb_dat_t    misc_dat, rb_dat;

   logic       set_stb;     // settings bus, fans out to readback and time
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_t vita_time, vita_time_pps;

   ////////////////////////////////////////////////////////////////////////////
   // bus decode and slaves

   wb_decoder wb_decoder0
      (.wb_adr_i(wb_adr_i), .wb_stb_i(wb_stb_i), .wb_cyc_i(wb_cyc_i),
       .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
       .misc_stb_o(misc_stb), .rb_stb_o(rb_stb), .set_stb_o(sb_stb),
       .misc_dat_i(misc_dat), .rb_dat_i(rb_dat),
       .misc_ack_i(misc_ack), .rb_ack_i(rb_ack), .set_ack_i(sb_ack));

   misc_regs misc_regs0  // slave 0
      (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
       .wb_we_i(wb_we_i), .wb_stb_i(misc_stb), .wb_dat_o(misc_dat), .wb_ack_o(misc_ack),
       .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
       .cgen_st_refmon_i(cgen_st_refmon_i),
       .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   settings_bus_16le settings_bus0  // slave 8
      (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
       .wb_we_i(wb_we_i), .wb_stb_i(sb_stb), .wb_ack_o(sb_ack),
       .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   readback_mux_16le readback_mux0  // slave 7
      (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_stb_i(rb_stb),
       .wb_dat_o(rb_dat), .wb_ack_o(rb_ack),
       .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
       .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

   ////////////////////////////////////////////////////////////////////////////
   // time base

   vita_time_64 #(.ticks_per_sec(ticks_per_sec)) vita_time0
      (.wb_clk(wb_clk), .wb_rst(wb_rst),
       .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
       .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

endmodule

// ==== source/readback_mux_16le.sv ====
`timescale 1ns/1ps

module readback_mux_16le import u1plus_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_adr_t    wb_adr_i,
   input  logic       wb_stb_i,
   output wb_dat_t    wb_dat_o,
   output logic       wb_ack_o,

   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i
);

   set_data_t reg_test32;
   set_data_t word_sel;
   wb_dat_t   hi_latch;    // upper half of the word read last
   logic      new_req;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_stb_i && (set_addr_i == SR_REG_TEST32))
         reg_test32 <= set_data_i;
   end

   // 32-bit word map, index from address bits 5..2
   always_comb
   begin
      case (wb_adr_i[5:2])
         4'd0:    word_sel = vita_time_i[63:32];
         4'd1:    word_sel = vita_time_i[31:0];
         4'd2:    word_sel = vita_time_pps_i[63:32];
         4'd3:    word_sel = vita_time_pps_i[31:0];
         4'd4:    word_sel = reg_test32;
         4'd6:    word_sel = COMPAT_NUM;
         default: word_sel = '0;
      endcase
   end

   assign new_req = wb_stb_i & ~wb_ack_o;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= new_req;
   end

   // low half read freezes the high half so the pair stays coherent
   always_ff @(posedge wb_clk)
   begin
      if (new_req)
      begin
         if (!wb_adr_i[1])
         begin
            wb_dat_o <= word_sel[15:0];
            hi_latch <= word_sel[31:16];
         end
         else
            wb_dat_o <= hi_latch;
      end
   end

endmodule

// ==== source/vita_time_64.sv ====
`timescale 1ns/1ps

module vita_time_64 import u1plus_pkg::*;
#(
   parameter int unsigned ticks_per_sec = DEFAULT_TICKS_PER_SEC
)
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);

   logic [31:0] secs_hold, ticks_hold;
   logic [31:0] secs, ticks;
   logic        load_mode, load_now, load_armed;
   logic        ticks_wr;
   logic        pps_meta, pps_sync, pps_dly, pps_edge;

   assign ticks_wr = set_stb_i && (set_addr_i == SR_TIME64 + 8'd1);

   ////////////////////////////////////////////////////////////////////////////
   // time load settings

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SR_TIME64))
         secs_hold <= set_data_i;
      if (ticks_wr)
         ticks_hold <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         load_mode  <= 1'b0;
         load_now   <= 1'b0;
         load_armed <= 1'b0;
      end
      else
      begin
         load_now <= ticks_wr & ~load_mode;
         if (set_stb_i && (set_addr_i == SR_TIME64 + 8'd2))
            load_mode <= set_data_i[0];
         if (ticks_wr && load_mode)
            load_armed <= 1'b1;  // wait for the next pps
         else if (pps_edge)
            load_armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pps sync and edge detect, edge is seen 3 cycles after the rise

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
         pps_edge <= 1'b0;
      end
      else
      begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
         pps_edge <= pps_sync & ~pps_dly;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // seconds / ticks counter

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs            <= '0;
         ticks           <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         if (pps_edge)
            vita_time_pps_o <= {secs, ticks};  // time at the detected edge
         if (load_now || (load_armed && pps_edge))
         begin
            secs  <= secs_hold;
            ticks <= ticks_hold;
         end
         else if (ticks == ticks_per_sec - 1)
         begin
            secs  <= secs + 32'd1;
            ticks <= '0;
         end
         else
            ticks <= ticks + 32'd1;
      end
   end

   assign vita_time_o = {secs, ticks};

endmodule

// ==== source/settings_bus_16le.sv ====
`timescale 1ns/1ps

module settings_bus_16le import u1plus_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   input  wb_adr_t   wb_adr_i,
   input  wb_dat_t   wb_dat_i,
   input  logic      wb_we_i,
   input  logic      wb_stb_i,
   output logic      wb_ack_o,

   output logic      set_stb_o,
   output set_addr_t set_addr_o,
   output set_data_t set_data_o
);

   wb_dat_t lo_half;   // first write of a pair
   logic    new_req;

   // single ack per held request
   assign new_req = wb_stb_i & ~wb_ack_o;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end
      else
      begin
         wb_ack_o  <= new_req;
         set_stb_o <= new_req & wb_we_i & wb_adr_i[1];  // high half completes the word
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (new_req && wb_we_i)
      begin
         if (!wb_adr_i[1])
            lo_half <= wb_dat_i;
         else
         begin
            set_addr_o <= wb_adr_i[9:2];
            set_data_o <= {wb_dat_i, lo_half};
         end
      end
   end

endmodule

// ==== source/misc_regs.sv ====
`timescale 1ns/1ps

module misc_regs import u1plus_pkg::*;
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  logic    wb_we_i,
   input  logic    wb_stb_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,

   input  logic    cgen_st_status_i,
   input  logic    cgen_st_ld_i,
   input  logic    cgen_st_refmon_i,
   output logic    cgen_sync_b_o,
   output logic    cgen_ref_sel_o
);

   logic [1:0] reg_cgen_ctrl;
   wb_dat_t    reg_test;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (wb_stb_i && wb_we_i)
      begin
         case (wb_adr_i[6:0])
            REG_CGEN_CTRL: reg_cgen_ctrl <= wb_dat_i[1:0];
            REG_TEST:      reg_test      <= wb_dat_i;
            default:       ;  // read-only or unmapped
         endcase
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl;

   always_comb
   begin
      case (wb_adr_i[6:0])
         REG_CGEN_CTRL: wb_dat_o = {14'd0, reg_cgen_ctrl};
         REG_CGEN_ST:   wb_dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      wb_dat_o = reg_test;
         default:       wb_dat_o = MISC_FILL;
      endcase
   end

   assign wb_ack_o = wb_stb_i;  // zero wait state, decoder already gated with cyc

endmodule

// ==== source/wb_decoder.sv ====
`timescale 1ns/1ps

module wb_decoder import u1plus_pkg::*;
(
   input  wb_adr_t wb_adr_i,
   input  logic    wb_stb_i,
   input  logic    wb_cyc_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,

   output logic    misc_stb_o,
   output logic    rb_stb_o,
   output logic    set_stb_o,
   input  wb_dat_t misc_dat_i,
   input  wb_dat_t rb_dat_i,
   input  logic    misc_ack_i,
   input  logic    rb_ack_i,
   input  logic    set_ack_i
);

   logic [3:0] dec_field;
   wb_slave_e  slave_sel;
   logic       req;

   assign dec_field = wb_adr_i[10:7];
   assign req       = wb_cyc_i & wb_stb_i;

   always_comb
   begin
      if ((dec_field & SLAVE_SETTINGS_MASK) == SLAVE_SETTINGS_ADDR)
         slave_sel = SETTINGS;
      else if (dec_field == SLAVE_MISC_ADDR)
         slave_sel = MISC;
      else if (dec_field == SLAVE_READBACK_ADDR)
         slave_sel = READBACK;
      else
         slave_sel = NONE;  // unused slots, never acked
   end

   assign misc_stb_o = req & (slave_sel == MISC);
   assign rb_stb_o   = req & (slave_sel == READBACK);
   assign set_stb_o  = req & (slave_sel == SETTINGS);

   // return path
   always_comb
   begin
      case (slave_sel)
         MISC:     begin wb_ack_o = misc_ack_i; wb_dat_o = misc_dat_i; end
         READBACK: begin wb_ack_o = rb_ack_i;   wb_dat_o = rb_dat_i;   end
         SETTINGS: begin wb_ack_o = set_ack_i;  wb_dat_o = '0;         end  // write only
         default:  begin wb_ack_o = 1'b0;       wb_dat_o = '0;         end
      endcase
   end

endmodule

// ==== source/u1plus_pkg.sv ====
package u1plus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus and setting types

   typedef logic [10:0] wb_adr_t;     // byte address from the master
   typedef logic [15:0] wb_dat_t;
   typedef logic [7:0]  set_addr_t;   // setting register number
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;  // seconds in [63:32], ticks in [31:0]

   // which slave a bus address lands on
   typedef enum logic [1:0] {MISC, READBACK, SETTINGS, NONE} wb_slave_e;

   ////////////////////////////////////////////////////////////////////////////
   // register map

   localparam set_addr_t SR_TIME64     = 8'd42;  // +0 secs, +1 ticks, +2 mode
   localparam set_addr_t SR_REG_TEST32 = 8'd60;

   // misc register offsets, address bits 6..0
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;

   ////////////////////////////////////////////////////////////////////////////
   // constants

   localparam logic [1:0] CGEN_CTRL_RESET = 2'b11;  // sync_b high, ref_sel high
   localparam wb_dat_t    MISC_FILL       = 16'hBEEF;
   localparam set_data_t  COMPAT_NUM      = {16'd9, 16'd0};  // major, minor

   localparam int unsigned DEFAULT_TICKS_PER_SEC = 64_000_000;

   // slave decode on address bits 10..7
   localparam logic [3:0] SLAVE_MISC_ADDR     = 4'd0;
   localparam logic [3:0] SLAVE_READBACK_ADDR = 4'd7;
   localparam logic [3:0] SLAVE_SETTINGS_ADDR = 4'd8;
   localparam logic [3:0] SLAVE_SETTINGS_MASK = 4'd8;  // settings spans 8 slots

endpackage
